// File: flist.f
+incdir+.
gcn_ctrl_pkg.sv
gcn_data_pkg.sv
gcn_adjacency.sv
gcn_agg_lane.sv
gcn_transform.sv
gcn_rank.sv
gcn_ctrl.sv
gcn_top.sv
gcn_checker.sv
gcn_tb.sv

// File: Bender.yml
package:
  name: gcn

sources:
  - include_dirs:
      - .
    files:
      - gcn_ctrl_pkg.sv
      - gcn_data_pkg.sv
      - gcn_adjacency.sv
      - gcn_agg_lane.sv
      - gcn_transform.sv
      - gcn_rank.sv
      - gcn_ctrl.sv
      - gcn_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - gcn_checker.sv
      - gcn_tb.sv

// File: gcn_tb.sv
`include "gcn_defs.svh"

module gcn_tb;

    localparam int          NUM_ROWS     = 7;
    localparam int          RESET_CYCLES = 8;
    localparam int          HALF_PERIOD  = 20;
    localparam int          DRIVE_DLY    = 2;
    localparam logic [31:0] SEED         = 32'h72acd3b0;

    // feature and weight modes
    localparam int F_RAND = 0;
    localparam int F_ZERO = 1;
    localparam int F_MAX  = 2;
    localparam int W_RAND = 0;
    localparam int W_MAX  = 1;

    logic                     clk;
    logic                     rst_n;
    logic                     start;
    logic                     feat_valid;
    logic                     feat_ready;
    logic                     done;
    gcn_ctrl_pkg::node_num_t  edge_src [`GCN_EDGES];
    gcn_ctrl_pkg::node_num_t  edge_dst [`GCN_EDGES];
    gcn_data_pkg::feat_t      feat_even [`GCN_NODES];
    gcn_data_pkg::feat_t      feat_odd [`GCN_NODES];
    gcn_data_pkg::wgt_t       wgt_even [`GCN_CLASSES];
    gcn_data_pkg::wgt_t       wgt_odd [`GCN_CLASSES];
    gcn_data_pkg::class_idx_t class_out [`GCN_NODES];
    logic [127:0]             test_name;
    int                       error_count;
    int                       check_count;
    logic [31:0]              rng;
    int                       cycle_cnt = 0;
    int                       cycle_limit = 0;

    //////////////////////////////////////////////////
    // test table with edge k in nibble k from the left
    //////////////////////////////////////////////////
    logic [127:0] row_name [NUM_ROWS];
    logic [23:0]  row_src [NUM_ROWS];
    logic [23:0]  row_dst [NUM_ROWS];
    int           row_fmode [NUM_ROWS];
    int           row_wmode [NUM_ROWS];
    int           row_gap [NUM_ROWS];
    int           row_key [NUM_ROWS];

    task automatic set_row(input int i, input logic [127:0] name, input logic [23:0] src,
                           input logic [23:0] dst, input int fm, input int wm,
                           input int gap, input int key);
        row_name[i]  = name;
        row_src[i]   = src;
        row_dst[i]   = dst;
        row_fmode[i] = fm;
        row_wmode[i] = wm;
        row_gap[i]   = gap;
        row_key[i]   = key;
    endtask

    task automatic load_table();
        set_row(0, "conn_rand",  24'h123456, 24'h234561, F_RAND, W_RAND, 0, 1);
        set_row(1, "zero_edges", 24'h000000, 24'h000000, F_RAND, W_RAND, 1, 2);
        set_row(2, "zero_feats", 24'h111235, 24'h234656, F_ZERO, W_RAND, 0, 3);
        // includes a self edge on node 3
        set_row(3, "dense_max",  24'h112343, 24'h345653, F_MAX,  W_MAX,  2, 4);
        // star on node 1 with a self edge at the hub
        // both rows share data and differ only in strobe spacing
        set_row(4, "gap0_star",  24'h111111, 24'h234561, F_RAND, W_RAND, 0, 5);
        set_row(5, "gap3_star",  24'h111111, 24'h234561, F_RAND, W_RAND, 3, 5);
        set_row(6, "b2b_pair",   24'h160000, 24'h620000, F_RAND, W_RAND, 0, 6);
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [4:0] next_value();
        rng = xorshift(rng);
        return rng[4:0];
    endfunction

    always #(HALF_PERIOD) clk = ~clk;

    gcn_top i_gcn_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .edge_src   (edge_src),
        .edge_dst   (edge_dst),
        .feat_valid (feat_valid),
        .feat_even  (feat_even),
        .feat_odd   (feat_odd),
        .wgt_even   (wgt_even),
        .wgt_odd    (wgt_odd),
        .feat_ready (feat_ready),
        .done       (done),
        .class_out  (class_out)
    );

    gcn_checker i_gcn_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .edge_src    (edge_src),
        .edge_dst    (edge_dst),
        .feat_valid  (feat_valid),
        .feat_even   (feat_even),
        .feat_odd    (feat_odd),
        .wgt_even    (wgt_even),
        .wgt_odd     (wgt_odd),
        .feat_ready  (feat_ready),
        .done        (done),
        .class_out   (class_out),
        .test_name   (test_name),
        .error_count (error_count),
        .check_count (check_count)
    );

    // run limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles in %0s, the DUT stopped responding",
                     cycle_cnt, test_name);
            $display("Regression failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////
    task automatic step();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    task automatic fill_data(input int fm, input int wm);
        for (int n = 0; n < `GCN_NODES; n++) begin
            feat_even[n] = (fm == F_RAND) ? next_value() : (fm == F_ZERO) ? 5'd0 : 5'd31;
            feat_odd[n]  = (fm == F_RAND) ? next_value() : (fm == F_ZERO) ? 5'd0 : 5'd31;
        end
        for (int c = 0; c < `GCN_CLASSES; c++) begin
            wgt_even[c] = (wm == W_RAND) ? next_value() : 5'd31;
            wgt_odd[c]  = (wm == W_RAND) ? next_value() : 5'd31;
        end
    endtask

    task automatic run_row(input int r);
        test_name = row_name[r];
        rng       = SEED ^ row_key[r];
        for (int e = 0; e < `GCN_EDGES; e++) begin
            edge_src[e] = row_src[r][(5 - e) * 4 +: 3];
            edge_dst[e] = row_dst[r][(5 - e) * 4 +: 3];
        end
        start = 1'b1;
        step();
        start = 1'b0;

        // stray strobe while the adjacency is still being built
        fill_data(F_RAND, W_RAND);
        feat_valid = 1'b1;
        step();
        feat_valid = 1'b0;
        while (feat_ready !== 1'b1)
            step();

        for (int p = 0; p < `GCN_FEATS / 2; p++) begin
            fill_data(row_fmode[r], row_wmode[r]);
            feat_valid = 1'b1;
            step();
            feat_valid = 1'b0;
            repeat (row_gap[r])
                step();
        end

        // a start during drain carries a different graph and must be dropped
        for (int e = 0; e < `GCN_EDGES; e++) begin
            edge_src[e] = 3'(e + 1);
            edge_dst[e] = 3'(`GCN_NODES - e);
        end
        start = 1'b1;
        step();
        start = 1'b0;
        while (done !== 1'b1)
            step();
        step();
    endtask

    initial begin
        int total;
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        feat_valid = 1'b0;
        test_name  = "reset";
        rng        = SEED;
        for (int e = 0; e < `GCN_EDGES; e++) begin
            edge_src[e] = '0;
            edge_dst[e] = '0;
        end
        fill_data(F_ZERO, W_RAND);
        for (int c = 0; c < `GCN_CLASSES; c++) begin
            wgt_even[c] = '0;
            wgt_odd[c]  = '0;
        end
        load_table();
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            total += 7 + 4 * (row_gap[r] + 1) + 12;
        cycle_limit = RESET_CYCLES + 2 * total;

        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DLY) rst_n = 1'b1;
        step();

        for (int r = 0; r < NUM_ROWS; r++)
            run_row(r);
        step();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: gcn_checker.sv
`include "gcn_defs.svh"

module gcn_checker (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  gcn_ctrl_pkg::node_num_t   edge_src [`GCN_EDGES],
    input  gcn_ctrl_pkg::node_num_t   edge_dst [`GCN_EDGES],
    input  logic                      feat_valid,
    input  gcn_data_pkg::feat_t       feat_even [`GCN_NODES],
    input  gcn_data_pkg::feat_t       feat_odd [`GCN_NODES],
    input  gcn_data_pkg::wgt_t        wgt_even [`GCN_CLASSES],
    input  gcn_data_pkg::wgt_t        wgt_odd [`GCN_CLASSES],
    input  logic                      feat_ready,
    input  logic                      done,
    input  gcn_data_pkg::class_idx_t  class_out [`GCN_NODES],
    input  logic [127:0]              test_name,
    output int                        error_count,
    output int                        check_count
);

    localparam int PAIRS = `GCN_FEATS / 2;

    int   adj [`GCN_NODES][`GCN_NODES];
    int   score [`GCN_NODES][`GCN_CLASSES];
    logic busy;
    logic in_reset;
    logic ready_seen;
    int   pairs;
    int   cyc;
    int   start_cyc;
    int   last_cyc;

    initial begin
        error_count = 0;
        check_count = 0;
    end

    //////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////

    // symmetric adjacency that skips edges with an unused end
    task automatic capture_edges();
        int s;
        int d;
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int k = 0; k < `GCN_NODES; k++)
                adj[n][k] = 0;
            for (int c = 0; c < `GCN_CLASSES; c++)
                score[n][c] = 0;
        end
        for (int e = 0; e < `GCN_EDGES; e++) begin
            s = edge_src[e];
            d = edge_dst[e];
            if (s != 0 && d != 0 && s <= `GCN_NODES && d <= `GCN_NODES) begin
                adj[s-1][d-1] = 1;
                adj[d-1][s-1] = 1;
            end
        end
    endtask

    // neighbour sums of both features weighted and added into the scores
    task automatic add_pair();
        int sum_e;
        int sum_o;
        for (int n = 0; n < `GCN_NODES; n++) begin
            sum_e = 0;
            sum_o = 0;
            for (int k = 0; k < `GCN_NODES; k++) begin
                if (adj[n][k] != 0) begin
                    sum_e += feat_even[k];
                    sum_o += feat_odd[k];
                end
            end
            for (int c = 0; c < `GCN_CLASSES; c++)
                score[n][c] += sum_e * wgt_even[c] + sum_o * wgt_odd[c];
        end
    endtask

    // argmax per node where a tie keeps the lower class
    task automatic compare_classes();
        int best;
        int expected;
        for (int n = 0; n < `GCN_NODES; n++) begin
            expected = 0;
            best     = score[n][0];
            for (int c = 1; c < `GCN_CLASSES; c++) begin
                if (score[n][c] > best) begin
                    best     = score[n][c];
                    expected = c;
                end
            end
            check_count++;
            if (class_out[n] !== expected[1:0]) begin
                error_count++;
                $display("MISMATCH %0s node %0d class expected %0d actual %0d",
                         test_name, n + 1, expected, class_out[n]);
            end
        end
    endtask

    task automatic check_reset();
        check_count++;
        if (feat_ready !== 1'b0 || done !== 1'b0) begin
            error_count++;
            $display("MISMATCH %0s feat_ready/done expected 0/0 actual %b/%b",
                     test_name, feat_ready, done);
        end
        for (int n = 0; n < `GCN_NODES; n++) begin
            if (class_out[n] !== 2'd0) begin
                error_count++;
                $display("MISMATCH %0s node %0d class expected 0 actual %0d",
                         test_name, n + 1, class_out[n]);
            end
        end
    endtask

    //////////////////////////////////////////////////
    // run tracking
    //////////////////////////////////////////////////
    task automatic watch_run();
        if (feat_ready && !ready_seen) begin
            ready_seen = 1'b1;
            if (cyc - start_cyc != 7) begin
                error_count++;
                $display("feat_ready rose %0d cycles after start instead of 7",
                         cyc - start_cyc);
            end
        end else if (!ready_seen && cyc - start_cyc > 7) begin
            ready_seen = 1'b1;
            error_count++;
            $display("feat_ready did not rise 7 cycles after start in %0s", test_name);
        end

        if (feat_ready && pairs == PAIRS) begin
            error_count++;
            $display("feat_ready still high after the last feature pair in %0s", test_name);
        end else if (feat_ready && feat_valid) begin
            add_pair();
            pairs++;
            if (pairs == PAIRS)
                last_cyc = cyc;
        end

        if (pairs == PAIRS && done) begin
            if (cyc - last_cyc != 8) begin
                error_count++;
                $display("done came %0d cycles after the last strobe instead of 8",
                         cyc - last_cyc);
            end
            compare_classes();
            busy = 1'b0;
        end else if (pairs == PAIRS && cyc - last_cyc >= 8) begin
            error_count++;
            $display("done missing 8 cycles after the last strobe in %0s", test_name);
            busy = 1'b0;
        end else if (done) begin
            error_count++;
            $display("done pulsed before all feature pairs were accepted in %0s", test_name);
            busy = 1'b0;
        end
    endtask

    // start is taken only when no run is active and done frees the engine the next cycle
    always @(posedge clk) begin
        if (!rst_n) begin
            busy     = 1'b0;
            in_reset = 1'b1;
            pairs    = 0;
            cyc      = 0;
        end else begin
            cyc = cyc + 1;
            if (in_reset) begin
                check_reset();
                in_reset = 1'b0;
            end
            if (busy) begin
                watch_run();
            end else begin
                // done is a single pulse, so it never shows up between runs
                if (done) begin
                    error_count++;
                    $display("done high with no run in progress");
                end
                if (start) begin
                    capture_edges();
                    busy       = 1'b1;
                    ready_seen = 1'b0;
                    pairs      = 0;
                    start_cyc  = cyc;
                end
            end
        end
    end

endmodule

// File: gcn_top.sv
`include "gcn_defs.svh"

module gcn_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    input  gcn_ctrl_pkg::node_num_t   edge_src [`GCN_EDGES],
    input  gcn_ctrl_pkg::node_num_t   edge_dst [`GCN_EDGES],
    input  logic                      feat_valid,
    input  gcn_data_pkg::feat_t       feat_even [`GCN_NODES],
    input  gcn_data_pkg::feat_t       feat_odd [`GCN_NODES],
    input  gcn_data_pkg::wgt_t        wgt_even [`GCN_CLASSES],
    input  gcn_data_pkg::wgt_t        wgt_odd [`GCN_CLASSES],
    output logic                      feat_ready,
    output logic                      done,
    output gcn_data_pkg::class_idx_t  class_out [`GCN_NODES]
);

    logic                   adj_start;
    logic                   adj_done;
    logic                   accept;
    logic                   rank_start;
    logic                   agg_valid;
    gcn_data_pkg::adj_row_t adj_rows [`GCN_NODES];
    gcn_data_pkg::agg_t     agg_even [`GCN_NODES];
    gcn_data_pkg::agg_t     agg_odd [`GCN_NODES];
    gcn_data_pkg::score_t   scores [`GCN_NODES][`GCN_CLASSES];

    gcn_ctrl i_gcn_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .feat_valid (feat_valid),
        .adj_done   (adj_done),
        .done       (done),
        .adj_start  (adj_start),
        .feat_ready (feat_ready),
        .accept     (accept),
        .rank_start (rank_start)
    );

    gcn_adjacency i_gcn_adjacency (
        .clk       (clk),
        .rst_n     (rst_n),
        .adj_start (adj_start),
        .edge_src  (edge_src),
        .edge_dst  (edge_dst),
        .adj_rows  (adj_rows),
        .adj_done  (adj_done)
    );

    // both lanes run in lockstep, the even one supplies the valid
    gcn_agg_lane lane_even (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .adj_rows  (adj_rows),
        .feat      (feat_even),
        .agg       (agg_even),
        .agg_valid (agg_valid)
    );

    gcn_agg_lane lane_odd (
        .clk       (clk),
        .rst_n     (rst_n),
        .accept    (accept),
        .adj_rows  (adj_rows),
        .feat      (feat_odd),
        .agg       (agg_odd),
        .agg_valid ()
    );

    gcn_transform i_gcn_transform (
        .clk       (clk),
        .rst_n     (rst_n),
        .adj_start (adj_start),
        .accept    (accept),
        .wgt_even  (wgt_even),
        .wgt_odd   (wgt_odd),
        .agg_even  (agg_even),
        .agg_odd   (agg_odd),
        .agg_valid (agg_valid),
        .scores    (scores)
    );

    gcn_rank i_gcn_rank (
        .clk        (clk),
        .rst_n      (rst_n),
        .rank_start (rank_start),
        .scores     (scores),
        .class_out  (class_out),
        .done       (done)
    );

endmodule

// File: gcn_ctrl.sv
`include "gcn_defs.svh"

module gcn_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic feat_valid,
    input  logic adj_done,
    input  logic done,
    output logic adj_start,
    output logic feat_ready,
    output logic accept,
    output logic rank_start
);

    gcn_ctrl_pkg::gcn_state_t state;
    gcn_ctrl_pkg::gcn_state_t next_state;
    gcn_ctrl_pkg::pair_cnt_t  pair_cnt;
    logic [1:0]               drain_cnt;
    logic                     last_pair;
    logic                     drain_end;

    //////////////////////////////////////////////////
    // handshake and strobes
    //////////////////////////////////////////////////

    // start counts only in idle, edges are taken the same cycle
    assign adj_start  = (state == gcn_ctrl_pkg::st_idle) && start;
    assign feat_ready = (state == gcn_ctrl_pkg::st_load);
    // strobes outside load are dropped
    assign accept     = feat_valid && feat_ready;
    assign last_pair  = accept && (pair_cnt == `GCN_FEATS/2 - 1);

    // four cycles cover lane and transform latency
    assign drain_end  = (state == gcn_ctrl_pkg::st_drain) && (drain_cnt == 2'd3);
    assign rank_start = drain_end;

    //////////////////////////////////////////////////
    // phase FSM
    //////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            gcn_ctrl_pkg::st_idle: begin
                if (start)
                    next_state = gcn_ctrl_pkg::st_adj;
            end
            gcn_ctrl_pkg::st_adj: begin
                if (adj_done)
                    next_state = gcn_ctrl_pkg::st_load;
            end
            gcn_ctrl_pkg::st_load: begin
                if (last_pair)
                    next_state = gcn_ctrl_pkg::st_drain;
            end
            gcn_ctrl_pkg::st_drain: begin
                if (drain_end)
                    next_state = gcn_ctrl_pkg::st_rank;
            end
            gcn_ctrl_pkg::st_rank: begin
                if (done)
                    next_state = gcn_ctrl_pkg::st_idle;
            end
            default: begin
                next_state = gcn_ctrl_pkg::st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= gcn_ctrl_pkg::st_idle;
        else
            state <= next_state;
    end

    // pair and drain counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pair_cnt  <= '0;
            drain_cnt <= '0;
        end else begin
            if (adj_start)
                pair_cnt <= '0;
            else if (accept)
                pair_cnt <= pair_cnt + 1'b1;

            if (state == gcn_ctrl_pkg::st_drain)
                drain_cnt <= drain_cnt + 2'd1;
            else
                drain_cnt <= '0;
        end
    end

endmodule

// File: gcn_rank.sv
`include "gcn_defs.svh"

module gcn_rank (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      rank_start,
    input  gcn_data_pkg::score_t      scores [`GCN_NODES][`GCN_CLASSES],
    output gcn_data_pkg::class_idx_t  class_out [`GCN_NODES],
    output logic                      done
);

    gcn_data_pkg::class_idx_t cls_cnt;
    logic                     busy;
    gcn_data_pkg::score_t     best_score [`GCN_NODES];
    gcn_data_pkg::class_idx_t best_idx [`GCN_NODES];
    gcn_data_pkg::score_t     next_score [`GCN_NODES];
    gcn_data_pkg::class_idx_t next_idx [`GCN_NODES];

    // class 0 always loads, later classes need a strictly larger score
    // so ties stay with the lower index
    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            if (cls_cnt == '0 || scores[n][cls_cnt] > best_score[n]) begin
                next_score[n] = scores[n][cls_cnt];
                next_idx[n]   = cls_cnt;
            end else begin
                next_score[n] = best_score[n];
                next_idx[n]   = best_idx[n];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            best_score <= next_score;
            best_idx   <= next_idx;
        end
    end

    //////////////////////////////////////////////////
    // class walk and result
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            cls_cnt <= '0;
            done    <= 1'b0;
            for (int n = 0; n < `GCN_NODES; n++)
                class_out[n] <= '0;
        end else begin
            done <= 1'b0;
            if (rank_start) begin
                busy    <= 1'b1;
                cls_cnt <= '0;
            end else if (busy) begin
                if (cls_cnt == `GCN_CLASSES - 1) begin
                    // last compare goes straight to the output
                    busy      <= 1'b0;
                    done      <= 1'b1;
                    class_out <= next_idx;
                end else begin
                    cls_cnt <= cls_cnt + 2'd1;
                end
            end
        end
    end

endmodule

// File: gcn_transform.sv
`include "gcn_defs.svh"

module gcn_transform (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                adj_start,
    input  logic                accept,
    input  gcn_data_pkg::wgt_t  wgt_even [`GCN_CLASSES],
    input  gcn_data_pkg::wgt_t  wgt_odd [`GCN_CLASSES],
    input  gcn_data_pkg::agg_t  agg_even [`GCN_NODES],
    input  gcn_data_pkg::agg_t  agg_odd [`GCN_NODES],
    input  logic                agg_valid,
    output gcn_data_pkg::score_t scores [`GCN_NODES][`GCN_CLASSES]
);

    // three stages, matching the lane latency
    gcn_data_pkg::wgt_t  wgt_even_d [3][`GCN_CLASSES];
    gcn_data_pkg::wgt_t  wgt_odd_d [3][`GCN_CLASSES];
    gcn_data_pkg::prod_t prod_even [`GCN_NODES][`GCN_CLASSES];
    gcn_data_pkg::prod_t prod_odd [`GCN_NODES][`GCN_CLASSES];
    logic                prod_valid;

    //////////////////////////////////////////////////
    // weight alignment and products
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            wgt_even_d[0] <= wgt_even;
            wgt_odd_d[0]  <= wgt_odd;
        end
        for (int s = 1; s < 3; s++) begin
            wgt_even_d[s] <= wgt_even_d[s-1];
            wgt_odd_d[s]  <= wgt_odd_d[s-1];
        end
        // prod_t is wide enough for the full product
        for (int n = 0; n < `GCN_NODES; n++) begin
            for (int c = 0; c < `GCN_CLASSES; c++) begin
                prod_even[n][c] <= agg_even[n] * wgt_even_d[2][c];
                prod_odd[n][c]  <= agg_odd[n] * wgt_odd_d[2][c];
            end
        end
    end

    //////////////////////////////////////////////////
    // lane sum and accumulation over features
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            for (int n = 0; n < `GCN_NODES; n++)
                for (int c = 0; c < `GCN_CLASSES; c++)
                    scores[n][c] <= '0;
        end else begin
            prod_valid <= agg_valid;
            if (adj_start) begin
                // new run starts from zero
                for (int n = 0; n < `GCN_NODES; n++)
                    for (int c = 0; c < `GCN_CLASSES; c++)
                        scores[n][c] <= '0;
            end else if (prod_valid) begin
                for (int n = 0; n < `GCN_NODES; n++)
                    for (int c = 0; c < `GCN_CLASSES; c++)
                        scores[n][c] <= scores[n][c] + prod_even[n][c] + prod_odd[n][c];
            end
        end
    end

endmodule

// File: gcn_agg_lane.sv
`include "gcn_defs.svh"

module gcn_agg_lane (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    accept,
    input  gcn_data_pkg::adj_row_t  adj_rows [`GCN_NODES],
    input  gcn_data_pkg::feat_t     feat [`GCN_NODES],
    output gcn_data_pkg::agg_t      agg [`GCN_NODES],
    output logic                    agg_valid
);

    gcn_data_pkg::feat_t masked [`GCN_NODES][`GCN_NODES];
    gcn_data_pkg::agg_t  part_lo [`GCN_NODES];
    gcn_data_pkg::agg_t  part_hi [`GCN_NODES];
    gcn_data_pkg::agg_t  sum_lo [`GCN_NODES];
    gcn_data_pkg::agg_t  sum_hi [`GCN_NODES];
    logic                valid_s1;
    logic                valid_s2;

    // valid bit follows the data through all three stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            agg_valid <= 1'b0;
        end else begin
            valid_s1  <= accept;
            valid_s2  <= valid_s1;
            agg_valid <= valid_s2;
        end
    end

    //////////////////////////////////////////////////
    // stage 1, features masked by each adjacency row
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int n = 0; n < `GCN_NODES; n++)
                for (int k = 0; k < `GCN_NODES; k++)
                    masked[n][k] <= adj_rows[n][k] ? feat[k] : '0;
        end
    end

    // half sums over nodes 1-3 and 4-6
    always_comb begin
        for (int n = 0; n < `GCN_NODES; n++) begin
            sum_lo[n] = '0;
            sum_hi[n] = '0;
            for (int k = 0; k < `GCN_NODES/2; k++) begin
                sum_lo[n] = sum_lo[n] + masked[n][k];
                sum_hi[n] = sum_hi[n] + masked[n][k + `GCN_NODES/2];
            end
        end
    end

    //////////////////////////////////////////////////
    // stages 2 and 3, partial sums then total
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        part_lo <= sum_lo;
        part_hi <= sum_hi;
        for (int n = 0; n < `GCN_NODES; n++)
            agg[n] <= part_lo[n] + part_hi[n];
    end

endmodule

// File: gcn_adjacency.sv
`include "gcn_defs.svh"

module gcn_adjacency (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     adj_start,
    input  gcn_ctrl_pkg::node_num_t  edge_src [`GCN_EDGES],
    input  gcn_ctrl_pkg::node_num_t  edge_dst [`GCN_EDGES],
    output gcn_data_pkg::adj_row_t   adj_rows [`GCN_NODES],
    output logic                     adj_done
);

    gcn_ctrl_pkg::node_num_t src_q [`GCN_EDGES];
    gcn_ctrl_pkg::node_num_t dst_q [`GCN_EDGES];
    logic [2:0]              edge_cnt;
    logic                    busy;
    gcn_data_pkg::adj_row_t  src_oh;
    gcn_data_pkg::adj_row_t  dst_oh;

    // node number to row bit, zero for an unused endpoint
    function automatic gcn_data_pkg::adj_row_t node_onehot(input gcn_ctrl_pkg::node_num_t n);
        node_onehot = '0;
        if (n != '0 && n <= `GCN_NODES)
            node_onehot[n - 3'd1] = 1'b1;
    endfunction

    // edge list is sampled together with the start strobe
    always_ff @(posedge clk) begin
        if (adj_start) begin
            src_q <= edge_src;
            dst_q <= edge_dst;
        end
    end

    // an edge with either end unused adds nothing
    always_comb begin
        src_oh = node_onehot(src_q[edge_cnt]);
        dst_oh = node_onehot(dst_q[edge_cnt]);
        if (src_oh == '0 || dst_oh == '0) begin
            src_oh = '0;
            dst_oh = '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            edge_cnt <= '0;
            for (int r = 0; r < `GCN_NODES; r++)
                adj_rows[r] <= '0;
        end else if (adj_start) begin
            busy     <= 1'b1;
            edge_cnt <= '0;
            for (int r = 0; r < `GCN_NODES; r++)
                adj_rows[r] <= '0;
        end else if (busy) begin
            // symmetric update, a self edge lands on the diagonal
            for (int r = 0; r < `GCN_NODES; r++)
                adj_rows[r] <= adj_rows[r] | (src_oh[r] ? dst_oh : '0) | (dst_oh[r] ? src_oh : '0);
            if (edge_cnt == `GCN_EDGES - 1)
                busy <= 1'b0;
            else
                edge_cnt <= edge_cnt + 3'd1;
        end
    end

    // high while the last edge is being applied
    assign adj_done = busy && (edge_cnt == `GCN_EDGES - 1);

endmodule

// File: gcn_data_pkg.sv
`include "gcn_defs.svh"

package gcn_data_pkg;

    //////////////////////////////////////////////////
    // inputs
    //////////////////////////////////////////////////

    typedef logic [`GCN_FEAT_W-1:0] feat_t;
    typedef logic [`GCN_WGT_W-1:0]  wgt_t;

    // bit k set means node k+1 is a neighbour
    typedef logic [`GCN_NODES-1:0]  adj_row_t;

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////

    // neighbour sum of one feature column
    typedef logic [`GCN_AGG_W-1:0] agg_t;

    // aggregate times one weight
    typedef logic [`GCN_AGG_W+`GCN_WGT_W-1:0] prod_t;

    // per node, per class running score
    typedef logic [`GCN_ACC_W-1:0] score_t;

    //////////////////////////////////////////////////
    // result
    //////////////////////////////////////////////////

    typedef logic [1:0] class_idx_t;

endpackage

// File: gcn_ctrl_pkg.sv
`include "gcn_defs.svh"

package gcn_ctrl_pkg;

    // engine phases
    typedef enum logic [2:0] {
        st_idle,
        st_adj,
        st_load,
        st_drain,
        st_rank
    } gcn_state_t;

    // edge endpoint, 1..6 with 0 for an unused edge
    typedef logic [2:0] node_num_t;

    // accepted feature pairs in one run
    typedef logic [$clog2(`GCN_FEATS/2 + 1)-1:0] pair_cnt_t;

endpackage

// File: gcn_defs.svh
`ifndef GCN_DEFS_SVH
`define GCN_DEFS_SVH

// graph size
`define GCN_NODES   6
`define GCN_EDGES   6

// features per node, consumed two at a time so keep it even
`define GCN_FEATS   8

// output classes per node
`define GCN_CLASSES 3

// data widths
`define GCN_FEAT_W  5
`define GCN_WGT_W   5

// neighbour sum of six features needs 3 extra bits
`define GCN_AGG_W   8

// class score accumulator
`define GCN_ACC_W   16

`endif
